// File: harness_pkg.sv
// Shared definitions for the SoC test harness
// Bus widths, address map, debug hold-off count, enums and boot ROM content

package harness_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned WordIdxWidth = 8;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  // Boot ROM, 16 words of 8 bytes
  localparam logic [AddrWidth-1:0] RomBase   = 32'h0001_0000;
  localparam int unsigned          RomWords  = 16;
  localparam logic [AddrWidth-1:0] RomLength = AddrWidth'(RomWords * StrbWidth);

  // DRAM, 256 words of 8 bytes
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam int unsigned          DramWords  = 256;
  localparam logic [AddrWidth-1:0] DramLength = AddrWidth'(DramWords * StrbWidth);

  // Last DRAM word doubles as the exit mailbox
  localparam logic [AddrWidth-1:0] ExitAddr  = 32'h8000_07F8;
  localparam int unsigned          ExitWidth = 32;

  // --------------------------------------------------------------------------
  // Debug request hold-off after reset
  // --------------------------------------------------------------------------
  localparam int unsigned DmiDelCycles  = 500;
  localparam int unsigned DelayCntWidth = 9;

  // Target of a decoded request
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_DRAM,
    REGION_ERR
  } region_e;

  // Bus controller states
  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } bus_state_e;

  // Boot ROM content: tag, index, inverted index
  function automatic logic [DataWidth-1:0] rom_word(input logic [WordIdxWidth-1:0] idx);
    logic [31:0] idx_ext;
    idx_ext = {{(32 - WordIdxWidth){1'b0}}, idx};
    return {16'hB007, idx_ext[15:0], ~idx_ext};
  endfunction

endpackage

// File: mem_bus_if.sv
// Word-addressed memory bus between the bus controller and one memory
// Request fields flow from master to slave, read data flows back

interface mem_bus_if;

  import harness_pkg::*;

  logic                    req;
  logic                    we;
  logic [WordIdxWidth-1:0] addr;
  logic [DataWidth-1:0]    wdata;
  logic [StrbWidth-1:0]    be;
  // Registered by the memory, valid the cycle after req
  logic [DataWidth-1:0]    rdata;

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rdata
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

// File: bus_fsm.sv
// Bus controller for the harness
// Accepts one request, decodes ROM, DRAM or error, and returns a single-cycle response

module bus_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output logic [harness_pkg::DataWidth-1:0] rdata_o,
  output logic                            err_o,
  mem_bus_if.master                       rom_o,
  mem_bus_if.master                       dram_o
);

  import harness_pkg::*;

  bus_state_e              state_d, state_q;
  region_e                 region_d, region_q;
  logic                    we_q;
  logic                    accept;
  logic [WordIdxWidth-1:0] word_idx;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  // Writes to the ROM fall through to the error region
  always_comb begin
    region_d = REGION_ERR;
    if (addr_i >= RomBase && addr_i < RomBase + RomLength && !we_i) begin
      region_d = REGION_ROM;
    end else if (addr_i >= DramBase && addr_i < DramBase + DramLength) begin
      region_d = REGION_DRAM;
    end
  end

  // Both bases are aligned well above the region sizes
  assign word_idx = addr_i[$clog2(StrbWidth) +: WordIdxWidth];

  // Handshake
  assign gnt_o  = (state_q == ST_IDLE);
  assign accept = req_i && gnt_o;

  // Memory requests only for legal accesses
  assign rom_o.req   = accept && (region_d == REGION_ROM);
  assign rom_o.we    = we_i;
  assign rom_o.addr  = word_idx;
  assign rom_o.wdata = wdata_i;
  assign rom_o.be    = be_i;

  assign dram_o.req   = accept && (region_d == REGION_DRAM);
  assign dram_o.we    = we_i;
  assign dram_o.addr  = word_idx;
  assign dram_o.wdata = wdata_i;
  assign dram_o.be    = be_i;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = ST_RESP;
      ST_RESP: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      region_q <= REGION_ERR;
      we_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        region_q <= region_d;
        we_q     <= we_i;
      end
    end
  end

  // Response, read data from the memory selected at accept
  assign rvalid_o = (state_q == ST_RESP);
  assign err_o    = rvalid_o && (region_q == REGION_ERR);

  always_comb begin
    rdata_o = '0;
    if (rvalid_o && !we_q) begin
      case (region_q)
        REGION_ROM:  rdata_o = rom_o.rdata;
        REGION_DRAM: rdata_o = dram_o.rdata;
        default:     rdata_o = '0;
      endcase
    end
  end

  // At most one response every second cycle
  a_rvalid_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni) rvalid_o |=> !rvalid_o
  );

endmodule

// File: debug_delay_gate.sv
// Debug request gate
// Blocks debug requests for a fixed window after reset and while debug is disabled

module debug_delay_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  import harness_pkg::*;

  logic [DelayCntWidth-1:0] cnt_d, cnt_q;
  logic                     window_done;

  // --------------------------------------------------------------------------
  // Hold-off counter
  // --------------------------------------------------------------------------
  // Gives the boot code time to run before a debug request can interrupt it
  assign window_done = (cnt_q == '0);
  assign cnt_d       = window_done ? cnt_q : cnt_q - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DelayCntWidth'(DmiDelCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Gate, combinational from the request
  assign debug_req_o = dbg_req_i && debug_enable_i && window_done;

  // Counter only ever counts down from the load value
  a_cnt_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni) cnt_q <= DelayCntWidth'(DmiDelCycles)
  );

endmodule

// File: boot_rom.sv
// Boot ROM
// Fixed content table with a registered read

module boot_rom (
  input logic      clk_i,
  input logic      rst_ni,
  mem_bus_if.slave bus_i
);

  import harness_pkg::*;

  // Content comes from the shared table function
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= rom_word(bus_i.addr);
    end
  end

  // The bus controller turns ROM writes into errors before they get here
  a_no_write : assert property (
    @(posedge clk_i) disable iff (!rst_ni) bus_i.req |-> !bus_i.we
  );

  // Decode keeps the index inside the ROM
  a_idx_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      bus_i.req |-> (int'(bus_i.addr) < RomWords)
  );

endmodule

// File: dram_mem.sv
// DRAM model with byte enables and a registered read
// Also holds the exit register written through the last DRAM word

module dram_mem (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  mem_bus_if.slave                          bus_i,
  output logic [harness_pkg::ExitWidth-1:0] exit_o
);

  import harness_pkg::*;

  logic [DataWidth-1:0] mem_q [DramWords];
  logic [ExitWidth-1:0] exit_q;
  logic                 exit_hit;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  // Write merges enabled bytes, read registers the whole word
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (bus_i.be[i]) begin
            mem_q[bus_i.addr][8*i +: 8] <= bus_i.wdata[8*i +: 8];
          end
        end
      end else begin
        bus_i.rdata <= mem_q[bus_i.addr];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Exit register
  // --------------------------------------------------------------------------
  // Word index of the exit address within DRAM
  assign exit_hit = bus_i.req && bus_i.we &&
                    (bus_i.addr == WordIdxWidth'((ExitAddr - DramBase) >> $clog2(StrbWidth)));

  // Low word is taken regardless of the byte enables
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_hit) begin
      exit_q <= bus_i.wdata[ExitWidth-1:0];
    end
  end

  assign exit_o = exit_q;

endmodule

// File: harness_top.sv
// SoC test harness top level
// Bus controller, boot ROM, DRAM with exit register and debug request gate

module harness_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Requester bus
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [harness_pkg::DataWidth-1:0] rdata_o,
  output logic                              err_o,

  // Debug and exit
  input  logic                              dbg_req_i,
  input  logic                              debug_enable_i,
  output logic                              debug_req_o,
  output logic [harness_pkg::ExitWidth-1:0] exit_o
);

  mem_bus_if rom_bus ();
  mem_bus_if dram_bus ();

  // --------------------------------------------------------------------------
  // Bus controller
  // --------------------------------------------------------------------------
  bus_fsm u_bus_fsm (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .req_i    ( req_i    ),
    .we_i     ( we_i     ),
    .addr_i   ( addr_i   ),
    .wdata_i  ( wdata_i  ),
    .be_i     ( be_i     ),
    .gnt_o    ( gnt_o    ),
    .rvalid_o ( rvalid_o ),
    .rdata_o  ( rdata_o  ),
    .err_o    ( err_o    ),
    .rom_o    ( rom_bus  ),
    .dram_o   ( dram_bus )
  );

  // --------------------------------------------------------------------------
  // Memories
  // --------------------------------------------------------------------------
  boot_rom u_boot_rom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus_i  ( rom_bus )
  );

  dram_mem u_dram_mem (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus_i  ( dram_bus ),
    .exit_o ( exit_o   )
  );

  // Debug request hold-off
  debug_delay_gate u_debug_delay_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .dbg_req_i      ( dbg_req_i      ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// File: tb_checker.sv
// Scoreboard for the SoC test harness
// Predicts bus responses, the exit register and the debug gate output

module tb_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic                              gnt_i,
  input  logic                              rvalid_i,
  input  logic [harness_pkg::DataWidth-1:0] rdata_i,
  input  logic                              err_i,
  input  logic                              dbg_req_i,
  input  logic                              debug_enable_i,
  input  logic                              debug_req_i,
  input  logic [harness_pkg::ExitWidth-1:0] exit_i,
  output int                                errors_o,
  output int                                checks_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import harness_pkg::*;

  logic [7:0]           dram_bytes [DramWords*StrbWidth];
  logic [ExitWidth-1:0] exp_exit;
  logic                 pend_valid;
  logic                 pend_err;
  logic [DataWidth-1:0] pend_rdata;
  logic                 pend_exit;
  logic [ExitWidth-1:0] pend_exit_val;
  int                   since_rst;
  int                   errors = 0;
  int                   checks = 0;

  assign errors_o = errors;
  assign checks_o = checks;

  task automatic flag_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic in_dram(input logic [AddrWidth-1:0] a);
    return (a >= DramBase) && (a < DramBase + DramLength);
  endfunction

  // ---------------------------------------------------------------------------
  // Reference response, {err, rdata}, from the address map and the DRAM model
  // ---------------------------------------------------------------------------
  function automatic logic [DataWidth:0] expect_response(input logic wr,
                                                         input logic [AddrWidth-1:0] a);
    logic [DataWidth-1:0] word;
    logic                 bad;
    int                   idx;
    word = '0;
    bad  = 1'b1;
    if (a >= RomBase && a < RomBase + RomLength && !wr) begin
      idx  = int'((a - RomBase) / StrbWidth);
      word = rom_word(WordIdxWidth'(idx));
      bad  = 1'b0;
    end else if (in_dram(a)) begin
      bad = 1'b0;
      if (!wr) begin
        idx = int'((a - DramBase) / StrbWidth);
        for (int b = 0; b < StrbWidth; b++) begin
          word[8*b +: 8] = dram_bytes[idx*StrbWidth + b];
        end
      end
    end
    return {bad, word};
  endfunction

  // Sampled on the falling edge, inputs only move on the rising edge
  always @(negedge clk_i) begin
    logic [DataWidth:0] exp_resp;
    logic               exp_dbg;
    int                 base;
    if (!rst_ni) begin
      pend_valid = 1'b0;
      pend_exit  = 1'b0;
      exp_exit   = '0;
      since_rst  = -1;
    end else begin
      since_rst++;

      // Response owed for the request accepted one cycle ago
      if (pend_valid) begin
        checks++;
        if (!rvalid_i) begin
          report_failure("no response one cycle after the request was accepted");
        end else begin
          if (rdata_i !== pend_rdata) flag_mismatch("rdata_o", pend_rdata, rdata_i);
          if (err_i !== pend_err) flag_mismatch("err_o", 64'(pend_err), 64'(err_i));
        end
        if (gnt_i) report_failure("grant was high during the response cycle");
        if (pend_exit) exp_exit = pend_exit_val;
        pend_valid = 1'b0;
      end else begin
        if (rvalid_i) report_failure("response without an accepted request");
        if (gnt_i !== 1'b1) report_failure("grant was low outside a response cycle");
      end

      if (exit_i !== exp_exit) flag_mismatch("exit_o", 64'(exp_exit), 64'(exit_i));

      // Gate opens once the hold-off window has run out
      exp_dbg = dbg_req_i && debug_enable_i && (since_rst >= int'(DmiDelCycles));
      if (debug_req_i !== exp_dbg) begin
        flag_mismatch("debug_req_o", 64'(exp_dbg), 64'(debug_req_i));
      end

      // Request accepted on the coming rising edge
      if (req_i && gnt_i) begin
        exp_resp      = expect_response(we_i, addr_i);
        pend_valid    = 1'b1;
        pend_err      = exp_resp[DataWidth];
        pend_rdata    = exp_resp[DataWidth-1:0];
        pend_exit     = we_i && in_dram(addr_i) &&
                        ((addr_i - DramBase) / StrbWidth == (ExitAddr - DramBase) / StrbWidth);
        pend_exit_val = wdata_i[ExitWidth-1:0];
        if (we_i && in_dram(addr_i)) begin
          base = int'((addr_i - DramBase) / StrbWidth) * StrbWidth;
          for (int b = 0; b < StrbWidth; b++) begin
            if (be_i[b]) dram_bytes[base + b] = wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: tb_top.sv
// Testbench top for the SoC test harness
// Clock, reset, bus stimulus and the debug gate sequence

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import harness_pkg::*;

  localparam int GntTimeout    = 20;
  localparam int RvalidTimeout = 20;
  localparam int DbgTimeout    = DmiDelCycles + 50;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;
  logic [StrbWidth-1:0] be;
  logic                 gnt;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;
  logic                 dbg_req;
  logic                 debug_enable;
  logic                 debug_req;
  logic [ExitWidth-1:0] exit_val;
  int                   seed = 32'h3de9_7c9c;
  int                   errors;
  int                   checks;
  int                   timeouts = 0;
  bit                   aborted = 1'b0;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  harness_top dut (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata),
    .be_i(be), .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata), .err_o(err),
    .dbg_req_i(dbg_req), .debug_enable_i(debug_enable), .debug_req_o(debug_req),
    .exit_o(exit_val)
  );

  tb_checker u_checker (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata),
    .be_i(be), .gnt_i(gnt), .rvalid_i(rvalid), .rdata_i(rdata), .err_i(err),
    .dbg_req_i(dbg_req), .debug_enable_i(debug_enable), .debug_req_i(debug_req),
    .exit_i(exit_val), .errors_o(errors), .checks_o(checks)
  );

  // ---------------------------------------------------------------------------
  // One bus access, waits for the grant and then the response
  // ---------------------------------------------------------------------------
  task automatic bus_access(input logic wr, input logic [AddrWidth-1:0] a,
                            input logic [DataWidth-1:0] d, input logic [StrbWidth-1:0] strb);
    int n;
    if (!aborted) begin
      @(posedge clk);
      req   <= 1'b1;
      we    <= wr;
      addr  <= a;
      wdata <= d;
      be    <= strb;
      n = 0;
      @(negedge clk);
      while (!gnt && n < GntTimeout) begin
        @(negedge clk);
        n++;
      end
      if (!gnt) begin
        $display("Timeout: no grant for the request to address %h", a);
        timeouts++;
        aborted = 1'b1;
      end else begin
        // Accepted on this edge
        @(posedge clk);
        req <= 1'b0;
        we  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid && n < RvalidTimeout) begin
          @(negedge clk);
          n++;
        end
        if (!rvalid) begin
          $display("Timeout: no response for the request to address %h", a);
          timeouts++;
          aborted = 1'b1;
        end
      end
    end
  endtask

  function automatic logic [DataWidth-1:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  initial begin
    logic [AddrWidth-1:0] a;
    int                   n;
    rst_n        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    be           = '0;
    dbg_req      = 1'b1;
    debug_enable = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // ROM reads
    for (int i = 0; i < 12; i++) begin
      a = RomBase + ($unsigned($random(seed)) % RomWords) * StrbWidth;
      bus_access(1'b0, a, '0, '0);
    end

    // DRAM full write, partial write, read back
    for (int i = 0; i < 16; i++) begin
      a = DramBase + ($unsigned($random(seed)) % (DramWords - 1)) * StrbWidth;
      bus_access(1'b1, a, random_word(), '1);
      bus_access(1'b1, a, random_word(), StrbWidth'($random(seed)));
      bus_access(1'b0, a, '0, '0);
    end

    // Unmapped accesses and ROM writes, DRAM word 0 must stay intact
    bus_access(1'b1, DramBase, random_word(), '1);
    bus_access(1'b0, 32'h0000_0000, '0, '0);
    bus_access(1'b0, RomBase + RomLength, '0, '0);
    bus_access(1'b1, DramBase + DramLength, random_word(), '1);
    bus_access(1'b0, DramBase - StrbWidth, '0, '0);
    bus_access(1'b1, RomBase, random_word(), '1);
    bus_access(1'b1, 32'h4000_0000, random_word(), 8'h0F);
    bus_access(1'b0, DramBase, '0, '0);

    // Exit register
    bus_access(1'b1, ExitAddr, random_word(), '1);
    bus_access(1'b0, ExitAddr, '0, '0);
    bus_access(1'b1, ExitAddr, random_word(), 8'hF0);
    bus_access(1'b0, ExitAddr, '0, '0);

    // Debug gate, request has been high since reset
    if (!aborted) begin
      n = 0;
      @(negedge clk);
      while (!debug_req && n < DbgTimeout) begin
        @(negedge clk);
        n++;
      end
      if (!debug_req) begin
        $display("Timeout: debug request never passed the gate");
        timeouts++;
      end
      @(posedge clk);
      debug_enable <= 1'b0;
      repeat (5) @(posedge clk);
      debug_enable <= 1'b1;
      repeat (5) @(posedge clk);
    end

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
harness_pkg.sv
mem_bus_if.sv
bus_fsm.sv
debug_delay_gate.sv
boot_rom.sv
dram_mem.sv
harness_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
# Verilator build and run for the SoC test harness

SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_top -f vlog.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
